//--- bpu_pkg.sv
package bpu_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    localparam int XLEN = 32;

    // ------------------------------------------------------------------------
    // Target buffer operations
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        NONE   = 2'd0,
        ADD    = 2'd1,
        UPDATE = 2'd2,
        REMOVE = 2'd3
    } btb_op_t;

    // ------------------------------------------------------------------------
    // Bundles passed between the stages
    // ------------------------------------------------------------------------

    // One prediction in flight through decode and execute
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            pred_taken;
        logic [XLEN-1:0] pred_target;
    } fetch_slot_t;

    // Outcome of the item in the execute slot
    typedef struct packed {
        logic            valid;
        logic            is_branch;
        logic            taken;
        logic [XLEN-1:0] target;
    } resolve_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        btb_op_t         op;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
    } btb_write_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            taken;
    } bht_update_t;

endpackage

//--- bpu_top.sv
module bpu_top
    import bpu_pkg::*;
#(
    parameter int BTB_INDEX_BITS = 6,
    parameter int BHT_INDEX_BITS = 7
)
(
    input  logic            CPU_CLK,
    input  logic            CPU_RST,
    input  logic [XLEN-1:0] fetch_pc,
    input  logic            fetch_valid,
    input  logic            stall,
    input  logic            flush,
    input  resolve_t        resolve,
    output logic            pred_taken,
    output logic [XLEN-1:0] pred_target,
    output redirect_t       redirect,
    output logic [31:0]     br_count,
    output logic [31:0]     mispredict_count
);

    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic            counter_taken;
    fetch_slot_t     ex_slot;
    btb_write_t      btb_wr;
    bht_update_t     bht_upd;

    // ------------------------------------------------------------------------
    // Fetch side and the two tables
    // ------------------------------------------------------------------------

    fetch_predict u_fetch_predict (
        .CPU_CLK       (CPU_CLK),
        .CPU_RST       (CPU_RST),
        .fetch_pc      (fetch_pc),
        .fetch_valid   (fetch_valid),
        .stall         (stall),
        .flush         (flush),
        .btb_hit       (btb_hit),
        .btb_target    (btb_target),
        .counter_taken (counter_taken),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .ex_slot       (ex_slot)
    );

    branch_target_buffer #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_btb (
        .CPU_CLK   (CPU_CLK),
        .CPU_RST   (CPU_RST),
        .lookup_pc (fetch_pc),
        .btb_wr    (btb_wr),
        .hit       (btb_hit),
        .target    (btb_target)
    );

    branch_history_table #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS)
    ) u_bht (
        .CPU_CLK       (CPU_CLK),
        .CPU_RST       (CPU_RST),
        .lookup_pc     (fetch_pc),
        .bht_upd       (bht_upd),
        .counter_taken (counter_taken)
    );

    // ------------------------------------------------------------------------
    // Execute side resolution
    // ------------------------------------------------------------------------

    branch_resolve u_branch_resolve (
        .CPU_CLK          (CPU_CLK),
        .CPU_RST          (CPU_RST),
        .ex_slot          (ex_slot),
        .resolve          (resolve),
        .stall            (stall),
        .btb_wr           (btb_wr),
        .bht_upd          (bht_upd),
        .redirect         (redirect),
        .br_count         (br_count),
        .mispredict_count (mispredict_count)
    );

endmodule

//--- branch_history_table.sv
module branch_history_table
    import bpu_pkg::*;
#(
    parameter int BHT_INDEX_BITS = 7
)
(
    input  logic            CPU_CLK,
    input  logic            CPU_RST,
    input  logic [XLEN-1:0] lookup_pc,
    input  bht_update_t     bht_upd,
    output logic            counter_taken
);

    localparam int ENTRIES = 2 ** BHT_INDEX_BITS;

    logic [1:0] cnt_q [ENTRIES];

    logic [BHT_INDEX_BITS-1:0] lookup_idx;
    logic [BHT_INDEX_BITS-1:0] upd_idx;
    logic [1:0]                upd_cnt;

    assign lookup_idx = lookup_pc[BHT_INDEX_BITS+1:2];
    assign upd_idx    = bht_upd.pc[BHT_INDEX_BITS+1:2];
    assign upd_cnt    = cnt_q[upd_idx];

    // Upper bit of the counter is the prediction
    assign counter_taken = cnt_q[lookup_idx][1];

    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            // Weakly not taken
            for (int i = 0; i < ENTRIES; i++)
            begin
                cnt_q[i] <= 2'd1;
            end
        end
        else if (bht_upd.valid)
        begin
            if (bht_upd.taken && (upd_cnt != 2'd3))
                cnt_q[upd_idx] <= upd_cnt + 2'd1;
            else if (!bht_upd.taken && (upd_cnt != 2'd0))
                cnt_q[upd_idx] <= upd_cnt - 2'd1;
        end
    end

    // Counter moves with the outcome and never wraps past 0 or 3
    assert property (@(posedge CPU_CLK) disable iff (CPU_RST)
        bht_upd.valid |=> ($past(bht_upd.taken) ?
            ({1'b0, cnt_q[$past(upd_idx)]} >= {1'b0, $past(upd_cnt)}) :
            ({1'b0, cnt_q[$past(upd_idx)]} <= {1'b0, $past(upd_cnt)})));

endmodule

//--- branch_resolve.sv
module branch_resolve
    import bpu_pkg::*;
(
    input  logic        CPU_CLK,
    input  logic        CPU_RST,
    input  fetch_slot_t ex_slot,
    input  resolve_t    resolve,
    input  logic        stall,
    output btb_write_t  btb_wr,
    output bht_update_t bht_upd,
    output redirect_t   redirect,
    output logic [31:0] br_count,
    output logic [31:0] mispredict_count
);

    logic            br_taken;
    logic            mispredict;
    logic [XLEN-1:0] fix_target;

    // ------------------------------------------------------------------------
    // Compare outcome with the carried prediction
    // ------------------------------------------------------------------------

    assign br_taken = resolve.is_branch & resolve.taken;

    // Taken needs the right target, anything else must not have been predicted
    always_comb
    begin
        if (!resolve.valid)
            mispredict = 1'b0;
        else if (br_taken)
            mispredict = !ex_slot.pred_taken || (ex_slot.pred_target != resolve.target);
        else
            mispredict = ex_slot.pred_taken;
    end

    assign fix_target = br_taken ? resolve.target : ex_slot.pc + XLEN'(4);

    // ------------------------------------------------------------------------
    // Table updates
    // ------------------------------------------------------------------------

    always_comb
    begin
        btb_wr.pc     = ex_slot.pc;
        btb_wr.target = resolve.target;
        if (!resolve.valid)
            btb_wr.op = NONE;
        else if (br_taken && !ex_slot.pred_taken)
            btb_wr.op = ADD;
        else if (br_taken && (ex_slot.pred_target != resolve.target))
            btb_wr.op = UPDATE;
        else if (!resolve.is_branch && ex_slot.pred_taken)
            btb_wr.op = REMOVE;
        else
            btb_wr.op = NONE;
    end

    assign bht_upd.valid = resolve.valid & resolve.is_branch;
    assign bht_upd.pc    = ex_slot.pc;
    assign bht_upd.taken = resolve.taken;

    // ------------------------------------------------------------------------
    // Registered redirect and statistics
    // ------------------------------------------------------------------------

    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            redirect         <= '0;
            br_count         <= '0;
            mispredict_count <= '0;
        end
        else
        begin
            redirect.valid  <= mispredict;
            redirect.target <= fix_target;
            if (bht_upd.valid)
                br_count <= br_count + 32'd1;
            if (mispredict)
                mispredict_count <= mispredict_count + 32'd1;
        end
    end

    // Outcome must belong to a live item that is leaving execute
    assert property (@(posedge CPU_CLK) disable iff (CPU_RST)
        resolve.valid |-> (ex_slot.valid && !stall));

endmodule

//--- branch_target_buffer.sv
module branch_target_buffer
    import bpu_pkg::*;
#(
    parameter int BTB_INDEX_BITS = 6
)
(
    input  logic            CPU_CLK,
    input  logic            CPU_RST,
    input  logic [XLEN-1:0] lookup_pc,
    input  btb_write_t      btb_wr,
    output logic            hit,
    output logic [XLEN-1:0] target
);

    localparam int ENTRIES  = 2 ** BTB_INDEX_BITS;
    localparam int TAG_BITS = XLEN - BTB_INDEX_BITS - 2;

    logic [ENTRIES-1:0]  valid_q;
    logic [TAG_BITS-1:0] tag_q    [ENTRIES];
    logic [XLEN-1:0]     target_q [ENTRIES];

    logic [BTB_INDEX_BITS-1:0] lookup_idx;
    logic [TAG_BITS-1:0]       lookup_tag;
    logic [BTB_INDEX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0]       wr_tag;
    logic                      wr_fill;

    // Byte offset bits of a word aligned pc are skipped
    assign lookup_idx = lookup_pc[BTB_INDEX_BITS+1:2];
    assign lookup_tag = lookup_pc[XLEN-1:BTB_INDEX_BITS+2];
    assign wr_idx     = btb_wr.pc[BTB_INDEX_BITS+1:2];
    assign wr_tag     = btb_wr.pc[XLEN-1:BTB_INDEX_BITS+2];

    assign wr_fill = (btb_wr.op == ADD) || (btb_wr.op == UPDATE);

    // ------------------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------------------

    assign hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target = target_q[lookup_idx];

    // ------------------------------------------------------------------------
    // Table writes
    // ------------------------------------------------------------------------

    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            valid_q <= '0;
        end
        else if (wr_fill)
        begin
            valid_q[wr_idx] <= 1'b1;
        end
        else if (btb_wr.op == REMOVE)
        begin
            valid_q[wr_idx] <= 1'b0;
        end
    end

    // Entry contents, qualified by valid_q
    always_ff @(posedge CPU_CLK)
    begin
        if (wr_fill)
        begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= btb_wr.target;
        end
    end

    // Resolution only removes an entry that is really there
    assert property (@(posedge CPU_CLK) disable iff (CPU_RST)
        (btb_wr.op == REMOVE) |-> (valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag)));

endmodule

//--- fetch_predict.sv
module fetch_predict
    import bpu_pkg::*;
(
    input  logic            CPU_CLK,
    input  logic            CPU_RST,
    input  logic [XLEN-1:0] fetch_pc,
    input  logic            fetch_valid,
    input  logic            stall,
    input  logic            flush,
    input  logic            btb_hit,
    input  logic [XLEN-1:0] btb_target,
    input  logic            counter_taken,
    output logic            pred_taken,
    output logic [XLEN-1:0] pred_target,
    output fetch_slot_t     ex_slot
);

    fetch_slot_t fetch_slot;
    fetch_slot_t id_slot;

    // ------------------------------------------------------------------------
    // Prediction for the current fetch address
    // ------------------------------------------------------------------------

    // Taken needs a stored target and a counter in the upper half
    assign pred_taken  = btb_hit & counter_taken;
    assign pred_target = pred_taken ? btb_target : fetch_pc + XLEN'(4);

    always_comb
    begin
        fetch_slot.valid       = fetch_valid;
        fetch_slot.pc          = fetch_pc;
        fetch_slot.pred_taken  = pred_taken;
        fetch_slot.pred_target = pred_target;
    end

    // ------------------------------------------------------------------------
    // Decode and execute slots
    // ------------------------------------------------------------------------

    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            id_slot <= '0;
            ex_slot <= '0;
        end
        else if (flush)
        begin
            // Flush beats stall, payload is left as it was
            id_slot.valid <= 1'b0;
            ex_slot.valid <= 1'b0;
        end
        else if (!stall)
        begin
            id_slot <= fetch_slot;
            ex_slot <= id_slot;
        end
    end

    // Nothing survives a flush into execute
    assert property (@(posedge CPU_CLK) disable iff (CPU_RST)
        flush |=> !ex_slot.valid);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_bpu -f tb.f -o sim_tb_bpu \
    && ./obj_dir/sim_tb_bpu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run step failed"; exit 1; }
cat sim.log
grep -q "^Simulation PASSED$" sim.log \
    && { echo "Result: pass"; exit 0; } \
    || { echo "Result: fail"; exit 1; }

//--- tb.f
bpu_pkg.sv
branch_target_buffer.sv
branch_history_table.sv
fetch_predict.sv
branch_resolve.sv
bpu_top.sv
tb_bpu.sv

//--- tb_bpu.sv
module tb_bpu
    import bpu_pkg::*;
();

    localparam logic [31:0] PC_POOL [4] = '{32'h0000_0100, 32'h0000_0204,
                                            32'h0000_0308, 32'h0000_040c};
    localparam logic [31:0] TGT_LIST [4] = '{32'h0000_1000, 32'h0000_2040,
                                             32'h0000_3080, 32'h0000_40c0};

    logic            CPU_CLK;
    logic            CPU_RST;
    logic [XLEN-1:0] fetch_pc;
    logic            fetch_valid;
    logic            stall;
    logic            flush;
    resolve_t        resolve;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;
    redirect_t       redirect;
    logic [31:0]     br_count;
    logic [31:0]     mispredict_count;

    // Reference model state keyed by pc
    // The pool never aliases in either table
    bit              m_valid [bit [31:0]];
    bit [31:0]       m_tgt [bit [31:0]];
    int              m_cnt [bit [31:0]];
    fetch_slot_t     m_id;
    fetch_slot_t     m_ex;
    int              exp_br;
    int              exp_mis;
    int              errors;
    integer          seed;
    logic            last_taken;
    logic [31:0]     last_target;
    logic [31:0]     r;

    bpu_top #(
        .BTB_INDEX_BITS (6),
        .BHT_INDEX_BITS (7)
    ) UUT (
        .CPU_CLK          (CPU_CLK),
        .CPU_RST          (CPU_RST),
        .fetch_pc         (fetch_pc),
        .fetch_valid      (fetch_valid),
        .stall            (stall),
        .flush            (flush),
        .resolve          (resolve),
        .pred_taken       (pred_taken),
        .pred_target      (pred_target),
        .redirect         (redirect),
        .br_count         (br_count),
        .mispredict_count (mispredict_count)
    );

    always #2 CPU_CLK = ~CPU_CLK;

    // Counts move by at most one per cycle
    assert property (@(posedge CPU_CLK) disable iff (CPU_RST)
        ((br_count - $past(br_count)) <= 32'd1) &&
        ((mispredict_count - $past(mispredict_count)) <= 32'd1))
    else
    begin
        errors++;
        $display("A count advanced by more than one in a single cycle");
    end

    // ------------------------------------------------------------------------
    // Model helpers and checks
    // ------------------------------------------------------------------------

    function automatic int counter_of(bit [31:0] pc);
        return m_cnt.exists(pc) ? m_cnt[pc] : 1;
    endfunction

    function automatic bit entry_hit(bit [31:0] pc);
        return m_valid.exists(pc) && m_valid[pc];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        assert (actv === expv)
        else
        begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expv, actv);
        end
    endtask

    // One cycle from falling edge to falling edge
    task automatic drive_cycle(input logic fv, input logic [31:0] pc, input logic st,
                               input logic fl, input logic is_br, input logic tk,
                               input logic [31:0] tgt, input string name);
        fetch_slot_t fs;
        logic        do_res;
        logic        br;
        logic        mis;
        logic [31:0] fix;
        int          c;
        do_res            = m_ex.valid && !st && !fl;
        fetch_valid       = fv;
        fetch_pc          = pc;
        stall             = st;
        flush             = fl;
        resolve.valid     = do_res;
        resolve.is_branch = is_br;
        resolve.taken     = tk;
        resolve.target    = tgt;
        fs.valid          = fv;
        fs.pc             = pc;
        fs.pred_taken     = entry_hit(pc) && (counter_of(pc) >= 2);
        fs.pred_target    = fs.pred_taken ? m_tgt[pc] : pc + 32'd4;
        #1;
        last_taken  = pred_taken;
        last_target = pred_target;
        check_value({name, " pred_taken"}, 32'(fs.pred_taken), 32'(pred_taken));
        check_value({name, " pred_target"}, fs.pred_target, pred_target);
        mis = 1'b0;
        fix = '0;
        if (do_res)
        begin
            br  = is_br && tk;
            mis = br ? (!m_ex.pred_taken || (m_ex.pred_target != tgt)) : m_ex.pred_taken;
            fix = br ? tgt : m_ex.pc + 32'd4;
            // A mispredicted taken branch writes its target into the entry
            if (br && mis)
            begin
                m_valid[m_ex.pc] = 1'b1;
                m_tgt[m_ex.pc]   = tgt;
            end
            else if (!is_br && m_ex.pred_taken)
            begin
                m_valid[m_ex.pc] = 1'b0;
            end
            if (is_br)
            begin
                c = counter_of(m_ex.pc);
                m_cnt[m_ex.pc] = tk ? ((c == 3) ? 3 : c + 1) : ((c == 0) ? 0 : c - 1);
                exp_br++;
            end
            if (mis)
                exp_mis++;
        end
        @(negedge CPU_CLK);
        if (fl)
        begin
            m_id.valid = 1'b0;
            m_ex.valid = 1'b0;
        end
        else if (!st)
        begin
            m_ex = m_id;
            m_id = fs;
        end
        check_value({name, " redirect.valid"}, 32'(mis), 32'(redirect.valid));
        if (mis)
            check_value({name, " redirect.target"}, fix, redirect.target);
        check_value({name, " br_count"}, exp_br, br_count);
        check_value({name, " mispredict_count"}, exp_mis, mispredict_count);
    endtask

    // Single item through an empty pipeline, resolved on the third cycle
    task automatic run_item(input logic [31:0] pc, input logic is_br, input logic tk,
                            input logic [31:0] tgt, input string name);
        drive_cycle(1'b1, pc, 1'b0, 1'b0, 1'b0, 1'b0, '0, name);
        drive_cycle(1'b0, pc, 1'b0, 1'b0, 1'b0, 1'b0, '0, name);
        drive_cycle(1'b0, pc, 1'b0, 1'b0, is_br, tk, tgt, name);
    endtask

    task automatic expect_prediction(input logic [31:0] pc, input logic taken,
                                     input logic [31:0] target, input string name);
        drive_cycle(1'b0, pc, 1'b0, 1'b0, 1'b0, 1'b0, '0, name);
        check_value({name, " explicit taken"}, 32'(taken), 32'(last_taken));
        check_value({name, " explicit target"}, target, last_target);
    endtask

    task automatic expect_redirect(input logic valid, input logic [31:0] target,
                                   input string name);
        check_value({name, " explicit redirect"}, 32'(valid), 32'(redirect.valid));
        if (valid)
            check_value({name, " explicit redirect target"}, target, redirect.target);
    endtask

    task automatic drain_pipeline();
        int n;
        n = 0;
        while ((m_id.valid || m_ex.valid) && (n < 10))
        begin
            drive_cycle(1'b0, PC_POOL[0], 1'b0, 1'b0, 1'b1, 1'b0, '0, "drain");
            n++;
        end
        if (m_id.valid || m_ex.valid)
        begin
            errors++;
            $display("Pipeline did not drain within 10 cycles");
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial
    begin
        logic [31:0] pc;
        logic [31:0] tgt;
        logic        fv;
        logic        st;
        logic        fl;
        logic        is_br;
        logic        tk;
        CPU_CLK     = 1'b0;
        CPU_RST     = 1'b1;
        fetch_pc    = '0;
        fetch_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        resolve     = '0;
        m_id        = '0;
        m_ex        = '0;
        exp_br      = 0;
        exp_mis     = 0;
        errors      = 0;
        seed        = 32'hd6207b12;
        repeat (3) @(posedge CPU_CLK);
        @(negedge CPU_CLK);
        CPU_RST = 1'b0;

        for (int i = 0; i < 4; i++)
            expect_prediction(PC_POOL[i], 1'b0, PC_POOL[i] + 32'd4, "after reset");

        // New entry and then a changed target at the same pc
        run_item(PC_POOL[0], 1'b1, 1'b1, TGT_LIST[0], "first taken");
        expect_redirect(1'b1, TGT_LIST[0], "first taken");
        expect_prediction(PC_POOL[0], 1'b1, TGT_LIST[0], "first taken lookup");
        run_item(PC_POOL[0], 1'b1, 1'b1, TGT_LIST[1], "changed target");
        expect_redirect(1'b1, TGT_LIST[1], "changed target");
        expect_prediction(PC_POOL[0], 1'b1, TGT_LIST[1], "changed target lookup");

        // Hysteresis
        run_item(PC_POOL[1], 1'b1, 1'b1, TGT_LIST[2], "hysteresis taken 1");
        run_item(PC_POOL[1], 1'b1, 1'b1, TGT_LIST[2], "hysteresis taken 2");
        expect_redirect(1'b0, '0, "hysteresis taken 2");
        run_item(PC_POOL[1], 1'b1, 1'b0, '0, "hysteresis not taken 1");
        expect_redirect(1'b1, PC_POOL[1] + 32'd4, "hysteresis not taken 1");
        expect_prediction(PC_POOL[1], 1'b1, TGT_LIST[2], "hysteresis lookup 1");
        run_item(PC_POOL[1], 1'b1, 1'b0, '0, "hysteresis not taken 2");
        expect_prediction(PC_POOL[1], 1'b0, PC_POOL[1] + 32'd4, "hysteresis lookup 2");

        run_item(PC_POOL[0], 1'b0, 1'b0, '0, "non-branch");
        expect_redirect(1'b1, PC_POOL[0] + 32'd4, "non-branch");
        expect_prediction(PC_POOL[0], 1'b0, PC_POOL[0] + 32'd4, "non-branch lookup");

        // Stall holds the predicted item in execute
        run_item(PC_POOL[2], 1'b1, 1'b1, TGT_LIST[0], "stall setup");
        drive_cycle(1'b1, PC_POOL[2], 1'b0, 1'b0, 1'b0, 1'b0, '0, "stall fetch");
        drive_cycle(1'b0, PC_POOL[3], 1'b0, 1'b0, 1'b0, 1'b0, '0, "stall advance");
        for (int i = 0; i < 3; i++)
            drive_cycle(1'b0, PC_POOL[3], 1'b1, 1'b0, 1'b0, 1'b0, '0, "stall hold");
        drive_cycle(1'b0, PC_POOL[3], 1'b0, 1'b0, 1'b1, 1'b1, TGT_LIST[0], "stall resolve");
        expect_redirect(1'b0, '0, "stall resolve");

        // Flushed items in decode and execute never resolve
        drive_cycle(1'b1, PC_POOL[1], 1'b0, 1'b0, 1'b0, 1'b0, '0, "flush fetch");
        drive_cycle(1'b1, PC_POOL[1], 1'b0, 1'b0, 1'b0, 1'b0, '0, "flush advance");
        drive_cycle(1'b0, PC_POOL[1], 1'b0, 1'b1, 1'b0, 1'b0, '0, "flush");
        for (int i = 0; i < 2; i++)
        begin
            drive_cycle(1'b0, PC_POOL[1], 1'b0, 1'b0, 1'b0, 1'b0, '0, "after flush");
            expect_redirect(1'b0, '0, "after flush");
        end
        run_item(PC_POOL[1], 1'b1, 1'b1, TGT_LIST[2], "after flush item");
        expect_redirect(1'b1, TGT_LIST[2], "after flush item");

        // Pipelined random traffic
        for (int i = 0; i < 300; i++)
        begin
            r     = $random(seed);
            pc    = PC_POOL[r[1:0]];
            fv    = r[2] | r[3];
            st    = (r[6:4] == 3'd0);
            fl    = (r[11:8] == 4'd0);
            is_br = (r[13:12] != 2'd0);
            tk    = r[14];
            tgt   = TGT_LIST[r[17:16]];
            // A predicted-taken non-branch needs its entry still present
            if (!is_br && m_ex.pred_taken && !entry_hit(m_ex.pc))
                is_br = 1'b1;
            drive_cycle(fv, pc, st, fl, is_br, tk, tgt, "random");
        end
        drain_pipeline();

        $display("Checks done: errors %0d, branches %0d, mispredicts %0d",
                 errors, exp_br, exp_mis);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        for (int i = 0; i < 5000; i++)
            @(posedge CPU_CLK);
        $display("Timeout after 5000 cycles, the stimulus did not finish");
        $display("Simulation FAILED");
        $finish;
    end

endmodule
